// File: verilog/zsp_macros.svh
`ifndef ZSP_MACROS_SVH
`define ZSP_MACROS_SVH

// datapath widths
`define ZSP_ADDR_W        48
`define ZSP_PAGE_ID_W     16
`define ZSP_THRESH_W      16  // threshold and event counter
`define ZSP_MAX_LINES_W   5

// geometry of one zspage, a single 4 KB way
`define ZSP_SLOTS         3
`define ZSP_LINE_BYTES    64
`define ZSP_LINE_SHIFT    6   // log2 of the line size
`define ZSP_MD_OFFSET     64  // slot 0 starts after the metadata line
`define ZSP_BASE_PAGE_B   256 // page bytes for size class 0

`endif

// File: verilog/zsp_pkg.sv
`default_nettype none

`include "zsp_macros.svh"

package zsp_pkg;

	typedef logic [`ZSP_ADDR_W-1:0] addr_t;        // byte address
	typedef logic [`ZSP_PAGE_ID_W-1:0] page_id_t;  // compressed page id
	typedef logic [1:0] size_cls_t;                // page = 256 << class, 3 acts as 2
	typedef logic [$clog2(`ZSP_SLOTS)-1:0] slot_t;

	// metadata line of one zspage
	typedef struct packed {
		size_cls_t                   size;
		logic [`ZSP_SLOTS-1:0]       vld;   // slot holds a page
		page_id_t [`ZSP_SLOTS-1:0]   page;
	} zsp_md_t;

	typedef struct packed {
		zsp_md_t md;
		logic    err;
	} md_rsp_t;

	// job for the external page migrator
	typedef struct packed {
		addr_t src_addr;
		addr_t dst_addr;
	} mig_pkt_t;

	typedef enum logic [1:0] {
		tbl_page_moved,
		tbl_free_way,
		tbl_detach_head,
		tbl_md_write
	} tbl_op_e;

	typedef struct packed {
		tbl_op_e  op;
		addr_t    way;
		page_id_t page_id;
		addr_t    new_addr;   // only for a page move
		zsp_md_t  md;
	} tbl_upd_t;

	typedef enum logic [3:0] {
		st_idle,
		st_fetch_src,
		st_wait_src,
		st_fetch_dst,
		st_wait_dst,
		st_read_lines,
		st_migrate,
		st_upd_page,
		st_free_src,
		st_detach_dst,
		st_check_list,
		st_write_back,
		st_done,
		st_bus_err
	} cmpt_state_e;

endpackage

`default_nettype wire

// File: verilog/zsp_compact_trigger.sv
`default_nettype none
`timescale 1ns/100ps

`include "zsp_macros.svh"

module zsp_compact_trigger (
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  logic                     decomp_done,
	input  logic [`ZSP_THRESH_W-1:0] cmpct_thresh,
	input  logic                     cmpt_done,
	output logic                     compact_req
);

	logic [`ZSP_THRESH_W:0] evt_cnt;   // one bit wider to hold threshold + 1
	logic [`ZSP_THRESH_W:0] thresh_x;

	assign thresh_x = {1'b0, cmpct_thresh};

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			evt_cnt     <= '0;
			compact_req <= 1'b0;
		end else begin
			// a finished compaction starts a fresh count
			if (cmpt_done) begin
				evt_cnt <= '0;
			end else if (decomp_done && (evt_cnt <= thresh_x)) begin
				evt_cnt <= evt_cnt + 1'b1;   // stops one above threshold
			end
			compact_req <= (evt_cnt >= thresh_x) && !cmpt_done;
		end
	end

endmodule

`default_nettype wire

// File: verilog/zsp_slot_picker.sv
`default_nettype none
`timescale 1ns/100ps

`include "zsp_macros.svh"

module zsp_slot_picker (
	input  zsp_pkg::zsp_md_t            src_md,
	input  zsp_pkg::zsp_md_t            dst_md,
	input  zsp_pkg::addr_t              src_way,
	input  zsp_pkg::addr_t              dst_way,
	output zsp_pkg::addr_t              src_addr,
	output zsp_pkg::addr_t              dst_addr,
	output zsp_pkg::page_id_t           page_id,
	output logic [`ZSP_MAX_LINES_W-1:0] line_cnt,
	output zsp_pkg::zsp_md_t            src_md_next,
	output zsp_pkg::zsp_md_t            dst_md_next,
	output logic                        src_empty_next,
	output logic                        dst_full_next
);
	import zsp_pkg::*;

	slot_t src_slot;
	slot_t dst_slot;
	addr_t src_pg;
	addr_t dst_pg;

	function automatic addr_t page_bytes(input size_cls_t cls);
		size_cls_t c;
		c = (cls > 2'd2) ? 2'd2 : cls;   // class 3 treated as 2
		return addr_t'(`ZSP_BASE_PAGE_B) << c;
	endfunction

	// lowest set bit wins
	function automatic slot_t lowest_set(input logic [`ZSP_SLOTS-1:0] mask);
		slot_t s;
		s = '0;
		for (int i = `ZSP_SLOTS - 1; i >= 0; i--) begin
			if (mask[i])
				s = slot_t'(i);
		end
		return s;
	endfunction

	assign src_slot = lowest_set(src_md.vld);
	assign dst_slot = lowest_set(~dst_md.vld);   // first free slot
	assign src_pg   = page_bytes(src_md.size);
	assign dst_pg   = page_bytes(dst_md.size);

	assign src_addr = src_way + addr_t'(`ZSP_MD_OFFSET) + addr_t'(src_slot) * src_pg;
	assign dst_addr = dst_way + addr_t'(`ZSP_MD_OFFSET) + addr_t'(dst_slot) * dst_pg;
	assign page_id  = src_md.page[src_slot];
	assign line_cnt = src_pg[`ZSP_LINE_SHIFT +: `ZSP_MAX_LINES_W];

	// metadata as it stands once the page has moved
	always_comb begin
		src_md_next                = src_md;
		dst_md_next                = dst_md;
		src_md_next.vld[src_slot]  = 1'b0;
		dst_md_next.vld[dst_slot]  = 1'b1;
		dst_md_next.page[dst_slot] = page_id;
	end

	assign src_empty_next = ~|src_md_next.vld;
	assign dst_full_next  = &dst_md_next.vld;

endmodule

`default_nettype wire

// File: verilog/zsp_line_reader.sv
`default_nettype none
`timescale 1ns/100ps

`include "zsp_macros.svh"

module zsp_line_reader (
	input  logic                        clk_i,
	input  logic                        rst_ni,
	input  logic                        start,
	input  zsp_pkg::addr_t              first_addr,
	input  logic [`ZSP_MAX_LINES_W-1:0] line_cnt,
	output logic                        rd_req_valid,
	input  logic                        rd_req_ready,
	output zsp_pkg::addr_t              rd_req_addr,
	input  logic                        rdfifo_full,
	input  logic                        rdfifo_empty,
	output logic                        lines_done
);
	import zsp_pkg::*;

	typedef enum logic [1:0] {
		lr_idle,
		lr_wait_empty,
		lr_issue
	} lr_state_e;

	lr_state_e                   state;
	logic [`ZSP_MAX_LINES_W-1:0] lines_left;
	logic                        rd_xfer;

	assign rd_req_valid = (state == lr_issue) && !rdfifo_full;   // hold off while FIFO full
	assign rd_xfer      = rd_req_valid && rd_req_ready;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state      <= lr_idle;
			lines_left <= '0;
			lines_done <= 1'b0;
		end else begin
			lines_done <= 1'b0;
			case (state)
				lr_idle: begin
					if (start) begin
						lines_left <= line_cnt;
						state      <= lr_wait_empty;
					end
				end
				lr_wait_empty: begin
					if (rdfifo_empty)
						state <= lr_issue;   // old read data drained
				end
				lr_issue: begin
					if (rd_xfer) begin
						lines_left <= lines_left - 1'b1;
						if (lines_left == 1) begin
							state      <= lr_idle;
							lines_done <= 1'b1;
						end
					end
				end
				default: state <= lr_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (start && (state == lr_idle))
			rd_req_addr <= first_addr;
		else if (rd_xfer)
			rd_req_addr <= rd_req_addr + addr_t'(`ZSP_LINE_BYTES);   // next line
	end

endmodule

`default_nettype wire

// File: verilog/zsp_compact_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module zsp_compact_ctrl (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              compact_trig,
	input  zsp_pkg::addr_t    ifl_head_way,
	input  zsp_pkg::addr_t    ifl_tail_way,
	output logic              md_req_valid,
	input  logic              md_req_ready,
	output zsp_pkg::addr_t    md_req_way,
	input  logic              md_rsp_valid,
	input  zsp_pkg::md_rsp_t  md_rsp,
	output zsp_pkg::zsp_md_t  src_md,
	output zsp_pkg::zsp_md_t  dst_md,
	output zsp_pkg::addr_t    src_way,
	output zsp_pkg::addr_t    dst_way,
	input  zsp_pkg::addr_t    src_addr,
	input  zsp_pkg::addr_t    dst_addr,
	input  zsp_pkg::page_id_t page_id,
	input  zsp_pkg::zsp_md_t  src_md_next,
	input  zsp_pkg::zsp_md_t  dst_md_next,
	input  logic              src_empty_next,
	input  logic              dst_full_next,
	output logic              line_start,
	input  logic              lines_done,
	output logic              migrate_start,
	input  logic              migrate_done,
	output zsp_pkg::mig_pkt_t mig_pkt,
	output logic              tbl_valid,
	input  logic              tbl_ready,
	output zsp_pkg::tbl_upd_t tbl_upd,
	output logic              cmpt_done,
	output logic              bus_err
);
	import zsp_pkg::*;

	cmpt_state_e state;
	cmpt_state_e state_n;
	logic        src_ld;      // source zspage metadata held
	logic        dst_ld;
	logic        src_empty;
	logic        dst_full;
	logic        list_one;    // head and tail are the same way
	logic        md_xfer;
	logic        tbl_xfer;
	logic        start_read;
	logic        load_src_way;
	logic        load_dst_way;
	page_id_t    moved_id;

	assign list_one      = (ifl_head_way == ifl_tail_way);
	assign md_req_valid  = (state == st_fetch_src) || (state == st_fetch_dst);
	assign md_req_way    = (state == st_fetch_dst) ? dst_way : src_way;
	assign md_xfer       = md_req_valid && md_req_ready;
	assign tbl_valid     = state inside {st_upd_page, st_free_src, st_detach_dst, st_write_back};
	assign tbl_xfer      = tbl_valid && tbl_ready;
	assign migrate_start = (state == st_migrate);
	assign bus_err       = (state == st_bus_err);

	assign start_read   = (state == st_check_list) && (state_n == st_read_lines);
	assign load_src_way = (state == st_check_list) && (state_n == st_fetch_src);
	assign load_dst_way = (state == st_check_list) && (state_n == st_fetch_dst);

	always_comb begin
		state_n = state;
		case (state)
			st_idle: begin
				if (compact_trig)
					state_n = list_one ? st_done : st_check_list;
			end
			st_check_list: begin
				if (list_one)
					state_n = (src_ld || dst_ld) ? st_write_back : st_done;
				else if (!src_ld)
					state_n = st_fetch_src;   // tail supplies the source
				else if (!dst_ld)
					state_n = st_fetch_dst;
				else
					state_n = st_read_lines;
			end
			st_fetch_src: if (md_xfer) state_n = st_wait_src;
			st_fetch_dst: if (md_xfer) state_n = st_wait_dst;
			st_wait_src: begin
				if (md_rsp_valid && md_rsp.err)
					state_n = st_bus_err;
				else if (md_rsp_valid)
					state_n = (|md_rsp.md.vld) ? st_check_list : st_free_src;
			end
			st_wait_dst: begin
				if (md_rsp_valid && md_rsp.err)
					state_n = st_bus_err;
				else if (md_rsp_valid)
					state_n = (&md_rsp.md.vld) ? st_detach_dst : st_check_list;
			end
			st_read_lines: if (lines_done) state_n = st_migrate;
			st_migrate: if (migrate_done) state_n = st_upd_page;
			st_upd_page: begin
				if (tbl_xfer) begin
					if (src_empty)
						state_n = st_free_src;
					else if (dst_full)
						state_n = st_detach_dst;
					else
						state_n = st_check_list;
				end
			end
			st_free_src: begin
				if (tbl_xfer)
					state_n = (dst_ld && dst_full) ? st_detach_dst : st_check_list;
			end
			st_detach_dst: if (tbl_xfer) state_n = st_check_list;
			st_write_back: if (tbl_xfer) state_n = st_done;
			st_done:       state_n = st_idle;
			st_bus_err:    state_n = st_bus_err;   // sticky until reset
			default:       state_n = st_idle;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state      <= st_idle;
			src_ld     <= 1'b0;
			dst_ld     <= 1'b0;
			src_empty  <= 1'b0;
			dst_full   <= 1'b0;
			line_start <= 1'b0;
			cmpt_done  <= 1'b0;
		end else begin
			state      <= state_n;
			line_start <= start_read;
			cmpt_done  <= (state == st_done);
			if ((state == st_wait_src) && md_rsp_valid && !md_rsp.err) begin
				src_ld    <= 1'b1;
				src_empty <= ~|md_rsp.md.vld;
			end
			if ((state == st_wait_dst) && md_rsp_valid && !md_rsp.err) begin
				dst_ld   <= 1'b1;
				dst_full <= &md_rsp.md.vld;
			end
			if ((state == st_migrate) && migrate_done) begin
				src_empty <= src_empty_next;
				dst_full  <= dst_full_next;
			end
			if ((state == st_free_src) && tbl_xfer)
				src_ld <= 1'b0;   // list drops its tail
			if ((state == st_detach_dst) && tbl_xfer)
				dst_ld <= 1'b0;
			if (state == st_done) begin
				src_ld <= 1'b0;
				dst_ld <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_src_way)
			src_way <= ifl_tail_way;
		if (load_dst_way)
			dst_way <= ifl_head_way;
		if ((state == st_wait_src) && md_rsp_valid)
			src_md <= md_rsp.md;
		if ((state == st_wait_dst) && md_rsp_valid)
			dst_md <= md_rsp.md;
		if (start_read) begin
			mig_pkt.src_addr <= src_addr;
			mig_pkt.dst_addr <= dst_addr;
			moved_id         <= page_id;
		end
		// commit the slot masks once the page is across
		if ((state == st_migrate) && migrate_done) begin
			src_md <= src_md_next;
			dst_md <= dst_md_next;
		end
	end

	always_comb begin
		tbl_upd = '0;
		case (state)
			st_upd_page: begin
				tbl_upd.op       = tbl_page_moved;
				tbl_upd.way      = src_way;
				tbl_upd.page_id  = moved_id;
				tbl_upd.new_addr = mig_pkt.dst_addr;
			end
			st_free_src: begin
				tbl_upd.op  = tbl_free_way;
				tbl_upd.way = src_way;
			end
			st_detach_dst: begin
				tbl_upd.op  = tbl_detach_head;
				tbl_upd.way = dst_way;
				tbl_upd.md  = dst_md;
			end
			st_write_back: begin
				tbl_upd.op  = tbl_md_write;   // the partial zspage left over
				tbl_upd.way = src_ld ? src_way : dst_way;
				tbl_upd.md  = src_ld ? src_md : dst_md;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/zsp_compacter.sv
`default_nettype none
`timescale 1ns/100ps

`include "zsp_macros.svh"

module zsp_compacter (
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  logic                     decomp_done,
	input  logic [`ZSP_THRESH_W-1:0] cmpct_thresh,
	output logic                     compact_req,
	input  logic                     compact_trig,
	output logic                     compact_done,
	input  zsp_pkg::addr_t           ifl_head_way,
	input  zsp_pkg::addr_t           ifl_tail_way,
	output logic                     md_req_valid,
	input  logic                     md_req_ready,
	output zsp_pkg::addr_t           md_req_way,
	input  logic                     md_rsp_valid,
	input  zsp_pkg::md_rsp_t         md_rsp,
	output logic                     rd_req_valid,
	input  logic                     rd_req_ready,
	output zsp_pkg::addr_t           rd_req_addr,
	input  logic                     rdfifo_full,
	input  logic                     rdfifo_empty,
	output logic                     migrate_start,
	input  logic                     migrate_done,
	output zsp_pkg::mig_pkt_t        mig_pkt,
	output logic                     tbl_valid,
	input  logic                     tbl_ready,
	output zsp_pkg::tbl_upd_t        tbl_upd,
	output logic                     bus_err
);
	import zsp_pkg::*;

	logic                        cmpt_done;
	zsp_md_t                     src_md;
	zsp_md_t                     dst_md;
	zsp_md_t                     src_md_next;
	zsp_md_t                     dst_md_next;
	addr_t                       src_way;
	addr_t                       dst_way;
	addr_t                       src_addr;
	addr_t                       dst_addr;
	page_id_t                    page_id;
	logic [`ZSP_MAX_LINES_W-1:0] line_cnt;
	logic                        src_empty_next;
	logic                        dst_full_next;
	logic                        line_start;
	logic                        lines_done;

	assign compact_done = cmpt_done;

	zsp_compact_trigger u_trigger (.*);

	zsp_slot_picker u_picker (.*);

	zsp_line_reader u_reader (
		.start      (line_start),
		.first_addr (src_addr),   // slot chosen by the picker
		.*
	);

	zsp_compact_ctrl u_ctrl (.*);

endmodule

`default_nettype wire

// File: testbench/tb_zsp_model.svh
	// free list as the model sees it, head at index 0
	addr_t    lst[$];
	zsp_md_t  md_mem[addr_t];
	addr_t    exp_md[$];
	addr_t    exp_rd[$];
	mig_pkt_t exp_mig[$];
	tbl_upd_t exp_tbl[$];

	function automatic addr_t head_of(input addr_t q[$]);
		return (q.size() == 0) ? '0 : q[0];
	endfunction

	function automatic addr_t tail_of(input addr_t q[$]);
		return (q.size() == 0) ? '0 : q[q.size()-1];
	endfunction

	function automatic int first_one(input logic [2:0] m);
		for (int i = 0; i < 3; i++) begin
			if (m[i])
				return i;
		end
		return 0;
	endfunction

	function automatic int page_size_of(input size_cls_t c);
		return 256 << ((c > 2'd2) ? 2'd2 : c);
	endfunction

	task automatic add_tbl(input tbl_op_e op, input addr_t way, input page_id_t id,
			input addr_t na, input zsp_md_t md);
		tbl_upd_t u;
		u          = '0;
		u.op       = op;
		u.way      = way;
		u.page_id  = id;
		u.new_addr = na;
		u.md       = md;
		exp_tbl.push_back(u);
	endtask

	// walk the whole compaction on a copy of the list
	task automatic build_expected();
		addr_t    q[$];
		zsp_md_t  smd;
		zsp_md_t  dmd;
		addr_t    sw;
		addr_t    dw;
		bit       s_ld;
		bit       d_ld;
		int       ss;
		int       ds;
		int       pg;
		addr_t    sa;
		addr_t    da;
		mig_pkt_t mp;
		page_id_t id;
		q    = lst;
		s_ld = 0;
		d_ld = 0;
		if (head_of(q) == tail_of(q))
			return;
		forever begin
			if (head_of(q) == tail_of(q)) begin
				if (s_ld)
					add_tbl(tbl_md_write, sw, '0, '0, smd);
				else if (d_ld)
					add_tbl(tbl_md_write, dw, '0, '0, dmd);
				break;
			end
			if (!s_ld) begin
				sw   = tail_of(q);
				smd  = md_mem[sw];
				s_ld = 1;
				exp_md.push_back(sw);
				if (smd.vld == 3'b000) begin   // nothing to move out
					add_tbl(tbl_free_way, sw, '0, '0, '0);
					void'(q.pop_back());
					s_ld = 0;
				end
			end else if (!d_ld) begin
				dw   = head_of(q);
				dmd  = md_mem[dw];
				d_ld = 1;
				exp_md.push_back(dw);
				if (dmd.vld == 3'b111) begin
					add_tbl(tbl_detach_head, dw, '0, '0, dmd);
					void'(q.pop_front());
					d_ld = 0;
				end
			end else begin
				ss = first_one(smd.vld);
				ds = first_one(~dmd.vld);
				pg = page_size_of(smd.size);
				sa = sw + 64 + addr_t'(ss * pg);
				da = dw + 64 + addr_t'(ds * pg);
				for (int i = 0; i < pg / 64; i++)
					exp_rd.push_back(sa + addr_t'(i * 64));
				mp.src_addr = sa;
				mp.dst_addr = da;
				exp_mig.push_back(mp);
				id              = smd.page[ss];
				smd.vld[ss]     = 1'b0;
				dmd.vld[ds]     = 1'b1;
				dmd.page[ds]    = id;
				add_tbl(tbl_page_moved, sw, id, da, '0);
				if (smd.vld == 3'b000) begin
					add_tbl(tbl_free_way, sw, '0, '0, '0);
					void'(q.pop_back());
					s_ld = 0;
				end
				if (dmd.vld == 3'b111) begin
					add_tbl(tbl_detach_head, dw, '0, '0, dmd);
					void'(q.pop_front());
					d_ld = 0;
				end
			end
		end
	endtask

// File: testbench/tb_zsp_compacter.sv
`default_nettype none
`timescale 1ns/100ps

`include "zsp_macros.svh"

module tb_zsp_compacter;
	import zsp_pkg::*;

	logic              clk_i;
	logic              rst_ni;
	logic              decomp_done;
	logic [15:0]       cmpct_thresh;
	logic              compact_req;
	logic              compact_trig;
	logic              compact_done;
	addr_t             ifl_head_way;
	addr_t             ifl_tail_way;
	logic              md_req_valid;
	logic              md_req_ready;
	addr_t             md_req_way;
	logic              md_rsp_valid;
	md_rsp_t           md_rsp;
	logic              rd_req_valid;
	logic              rd_req_ready;
	addr_t             rd_req_addr;
	logic              rdfifo_full;
	logic              rdfifo_empty;
	logic              migrate_start;
	logic              migrate_done;
	mig_pkt_t          mig_pkt;
	logic              tbl_valid;
	logic              tbl_ready;
	tbl_upd_t          tbl_upd;
	logic              bus_err;

	int       mismatch_cnt;
	int       fail_cnt;
	int       cycles;
	int       cycle_limit;
	bit       err_mode;
	bit       err_seen;
	bit       empty_seen;
	int       rsp_wait;     // -1 when no response is owed
	addr_t    rsp_way;
	bit       mig_busy;
	int       mig_wait;
	mig_pkt_t mig_cur;

	`include "tb_zsp_model.svh"

	zsp_compacter UUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		md_req_ready <= 1'($urandom % 2);
		rd_req_ready <= 1'($urandom % 2);
		tbl_ready    <= 1'($urandom % 2);
		rdfifo_full  <= ($urandom % 4) == 0;
		rdfifo_empty <= 1'($urandom % 2);
		cycles       <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles waiting for the DUT", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// metadata port
	always @(posedge clk_i) begin
		md_rsp_valid <= 1'b0;
		if (rsp_wait == 0) begin
			md_rsp_valid <= 1'b1;
			md_rsp.md    <= md_mem.exists(rsp_way) ? md_mem[rsp_way] : '0;
			md_rsp.err   <= err_mode;
			rsp_wait     <= -1;
		end else if (rsp_wait > 0) begin
			rsp_wait <= rsp_wait - 1;
		end
		if (md_req_valid && md_req_ready) begin
			if (exp_md.size() == 0) begin
				$display("metadata request for way %h that was not expected", md_req_way);
				fail_cnt++;
			end else begin
				assert (md_req_way == exp_md[0]) else begin
					$display("mismatch md_req_way: got %h expected %h", md_req_way, exp_md[0]);
					mismatch_cnt++;
				end
				void'(exp_md.pop_front());
			end
			rsp_way  <= md_req_way;
			rsp_wait <= $urandom % 4;
		end
	end

	// line reads
	always @(posedge clk_i) begin
		if (tbl_valid && tbl_ready && (tbl_upd.op == tbl_page_moved))
			empty_seen <= 1'b0;   // next page waits for the FIFO again
		else if (rdfifo_empty)
			empty_seen <= 1'b1;
		assert (!(rd_req_valid && rdfifo_full)) else begin
			$display("line read request raised while the read FIFO was full");
			fail_cnt++;
		end
		if (rd_req_valid && rd_req_ready) begin
			assert (empty_seen) else begin
				$display("line read issued before the read FIFO was seen empty");
				fail_cnt++;
			end
			if (exp_rd.size() == 0) begin
				$display("line read at %h that was not expected", rd_req_addr);
				fail_cnt++;
			end else begin
				assert (rd_req_addr == exp_rd[0]) else begin
					$display("mismatch rd_req_addr: got %h expected %h", rd_req_addr, exp_rd[0]);
					mismatch_cnt++;
				end
				void'(exp_rd.pop_front());
			end
		end
	end

	// page migrator
	always @(posedge clk_i) begin
		if (migrate_start && !mig_busy) begin
			if (exp_mig.size() == 0) begin
				$display("migration started that was not expected");
				fail_cnt++;
			end else begin
				assert (mig_pkt == exp_mig[0]) else begin
					$display("mismatch mig_pkt: got %h expected %h", mig_pkt, exp_mig[0]);
					mismatch_cnt++;
				end
				void'(exp_mig.pop_front());
			end
			mig_cur  <= mig_pkt;
			mig_busy <= 1'b1;
			mig_wait <= $urandom % 5;
		end else if (mig_busy) begin
			assert (mig_pkt == mig_cur) else begin
				$display("mismatch mig_pkt: got %h expected %h", mig_pkt, mig_cur);
				mismatch_cnt++;
			end
			if (migrate_done) begin
				migrate_done <= 1'b0;
				mig_busy     <= 1'b0;
			end else if (mig_wait == 0) begin
				migrate_done <= 1'b1;
			end else begin
				mig_wait <= mig_wait - 1;
			end
		end
	end

	// table updates, which also move the list ends
	always @(posedge clk_i) begin
		if (tbl_valid && tbl_ready) begin
			if (exp_tbl.size() == 0) begin
				$display("table update op %h that was not expected", tbl_upd.op);
				fail_cnt++;
			end else begin
				assert (tbl_upd == exp_tbl[0]) else begin
					$display("mismatch tbl_upd: got %h expected %h", tbl_upd, exp_tbl[0]);
					mismatch_cnt++;
				end
				void'(exp_tbl.pop_front());
			end
			if (tbl_upd.op == tbl_free_way)
				void'(lst.pop_back());
			if (tbl_upd.op == tbl_detach_head)
				void'(lst.pop_front());
		end
		ifl_head_way <= head_of(lst);
		ifl_tail_way <= tail_of(lst);
		if (err_seen) begin
			assert (bus_err && !md_req_valid && !rd_req_valid && !tbl_valid && !migrate_start)
			else begin
				$display("output active after the bus error");
				fail_cnt++;
			end
		end
	end

	task automatic make_list(input int n, input int run);
		size_cls_t cls;
		zsp_md_t   md;
		cls = size_cls_t'($urandom % 4);
		lst.delete();
		md_mem.delete();
		for (int i = 0; i < n; i++) begin
			md.size = cls;
			md.vld  = 3'($urandom % 8);
			for (int s = 0; s < 3; s++)
				md.page[s] = page_id_t'($urandom);
			lst.push_back(addr_t'(32'h4000 + run * 16 + i) << 12);
			md_mem[lst[i]] = md;
		end
	endtask

	task automatic trigger_and_wait();
		@(posedge clk_i);
		compact_trig <= 1'b1;
		@(posedge clk_i);
		compact_trig <= 1'b0;
		do
			@(negedge clk_i);
		while (!compact_done);
	endtask

	task automatic count_events(input int thresh);
		@(posedge clk_i);
		cmpct_thresh <= 16'(thresh);
		@(negedge clk_i);
		for (int i = 0; i < thresh; i++) begin
			assert (!compact_req) else begin
				$display("mismatch compact_req: got %h expected 0", compact_req);
				mismatch_cnt++;
			end
			@(posedge clk_i);
			decomp_done <= 1'b1;
			@(posedge clk_i);
			decomp_done <= 1'b0;
			@(posedge clk_i);
			@(negedge clk_i);
		end
		assert (compact_req) else begin
			$display("mismatch compact_req: got %h expected 1", compact_req);
			mismatch_cnt++;
		end
	endtask

	task automatic queues_drained();
		assert (exp_md.size() + exp_rd.size() + exp_mig.size() + exp_tbl.size() == 0)
		else begin
			$display("compaction ended with expected requests still outstanding");
			fail_cnt++;
		end
	endtask

	initial begin
		void'($urandom(32'hc8652758));
		rst_ni       = 1'b0;
		decomp_done  = 1'b0;
		cmpct_thresh = 16'd1;
		compact_trig = 1'b0;
		ifl_head_way = '0;
		ifl_tail_way = '0;
		md_req_ready = 1'b0;
		md_rsp_valid = 1'b0;
		md_rsp       = '0;
		rd_req_ready = 1'b0;
		rdfifo_full  = 1'b0;
		rdfifo_empty = 1'b1;
		migrate_done = 1'b0;
		tbl_ready    = 1'b0;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		cycles       = 0;
		cycle_limit  = 2000;
		err_mode     = 0;
		err_seen     = 0;
		empty_seen   = 0;
		rsp_wait     = -1;
		mig_busy     = 0;
		mig_wait     = 0;
		repeat (3) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(negedge clk_i);

		for (int run = 0; run < 6; run++) begin
			make_list(2 + $urandom % 5, run);
			build_expected();
			cycles      <= 0;
			cycle_limit <= 40 * (exp_rd.size() + exp_tbl.size()) + 2000;
			count_events(1 + $urandom % 4);
			trigger_and_wait();
			@(negedge clk_i);
			assert (!compact_req) else begin
				$display("mismatch compact_req: got %h expected 0", compact_req);
				mismatch_cnt++;
			end
			queues_drained();
		end

		// single zspage left, nothing to do
		make_list(1, 7);
		cycles <= 0;
		trigger_and_wait();
		queues_drained();

		// metadata error goes sticky
		make_list(3, 8);
		exp_md.push_back(tail_of(lst));
		err_mode = 1;
		cycles <= 0;
		@(posedge clk_i);
		compact_trig <= 1'b1;
		@(posedge clk_i);
		compact_trig <= 1'b0;
		do
			@(negedge clk_i);
		while (!bus_err);
		queues_drained();
		err_seen = 1;
		repeat (20) @(posedge clk_i);
		err_seen = 0;
		rst_ni <= 1'b0;
		repeat (3) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(negedge clk_i);
		assert (!bus_err) else begin
			$display("mismatch bus_err: got %h expected 0", bus_err);
			mismatch_cnt++;
		end

		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
+incdir+testbench
verilog/zsp_pkg.sv
verilog/zsp_compact_trigger.sv
verilog/zsp_slot_picker.sv
verilog/zsp_line_reader.sv
verilog/zsp_compact_ctrl.sv
verilog/zsp_compacter.sv
testbench/tb_zsp_compacter.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_zsp_compacter
FLIST      := list.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FLIST)) $(wildcard verilog/*.svh testbench/*.svh)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
